// File: logic/ctrl_types_pkg.sv
`default_nettype none

package ctrl_types_pkg;

	// which hazard rule won this cycle
	typedef enum logic [2:0] {
		CAUSE_NONE       = 3'd0,
		CAUSE_MEM        = 3'd1, // memory exchange still open
		CAUSE_BR_SYSCALL = 3'd2,
		CAUSE_LD_ST      = 3'd3,
		CAUSE_LOAD_USE   = 3'd4,
		CAUSE_JUMP       = 3'd5,
		CAUSE_TRAP       = 3'd6,
		CAUSE_TAKEN      = 3'd7  // taken branch resolved in MEM
	} stall_cause_t;

	// direction of the memory exchange
	typedef enum logic {
		MEM_RD = 1'b0,
		MEM_WR = 1'b1
	} mem_op_t;

endpackage

`default_nettype wire

// File: logic/hazard_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module hazard_ctrl
	import pipe_types_pkg::*;
	import ctrl_types_pkg::*;
(
	stage_ctrl_if.ctrl   ctl,
	input  wire instr_t  ifid,
	input  wire instr_t  idex,
	input  wire instr_t  exmem,
	input  wire logic    mem_ready,
	input  wire logic    int_trap
);

	logic ifid_syscall, ifid_load, ifid_jump;
	logic idex_branch, idex_store, idex_load;
	logic exmem_branch, load_use, taken_in_mem;
	stall_cause_t cause;

	assign ifid_syscall = ifid.valid && (ifid.op == OP_SYSCALL);
	assign ifid_load    = ifid.valid && (ifid.op == OP_LOAD);
	assign ifid_jump    = ifid.valid && (ifid.op == OP_JUMP);
	assign idex_branch  = idex.valid && (idex.op == OP_BRANCH);
	assign idex_store   = idex.valid && (idex.op == OP_STORE);
	assign idex_load    = idex.valid && (idex.op == OP_LOAD);
	assign exmem_branch = exmem.valid && (exmem.op == OP_BRANCH);
	assign taken_in_mem = exmem_branch && exmem.taken;

	// no forwarding, any match on a source register stalls
	assign load_use = idex_load && ifid.valid &&
		((idex.rd == ifid.rs) || (idex.rd == ifid.rt));

	always_comb begin
		cause            = CAUSE_NONE;
		ctl.write_pc     = 1'b1;
		ctl.write_ifid   = 1'b1;
		ctl.write_idex   = 1'b1;
		ctl.write_exmem  = 1'b1;
		ctl.write_memwb  = 1'b1;
		ctl.bubble_ifid  = 1'b0;
		ctl.bubble_idex  = 1'b0;
		ctl.bubble_exmem = 1'b0;
		ctl.trap_waiting = ifid_syscall;

		if (!mem_ready) begin // freeze everything, MEM/WB included
			cause            = CAUSE_MEM;
			ctl.write_pc     = 1'b0;
			ctl.write_ifid   = 1'b0;
			ctl.write_idex   = 1'b0;
			ctl.write_exmem  = 1'b0;
			ctl.write_memwb  = 1'b0;
			ctl.trap_waiting = 1'b0;
		end else if (ifid_syscall && (idex_branch || exmem_branch)) begin
			// let the branch resolve before the syscall can trap
			cause            = CAUSE_BR_SYSCALL;
			ctl.bubble_idex  = 1'b1;
			ctl.write_idex   = 1'b0;
			ctl.write_ifid   = 1'b0;
			ctl.write_pc     = 1'b0; // fetch must wait while IF/ID is held
			ctl.trap_waiting = 1'b0;
		end else if (ifid_load && idex_store) begin
			cause           = CAUSE_LD_ST;
			ctl.bubble_idex = 1'b1;
			ctl.write_idex  = 1'b0;
			ctl.write_ifid  = 1'b0;
			ctl.write_pc    = 1'b0;
		end else if (load_use) begin
			cause           = CAUSE_LOAD_USE;
			ctl.bubble_idex = 1'b1;
			ctl.write_idex  = 1'b0;
			ctl.write_ifid  = 1'b0;
			ctl.write_pc    = 1'b0;
		end else if (ifid_jump) begin
			cause           = CAUSE_JUMP;
			ctl.bubble_ifid = 1'b1; // squash the slot fetched behind the jump
			ctl.write_ifid  = 1'b0;
		end

		// flushes override the stall chain, but never a memory wait
		if (mem_ready && (int_trap || taken_in_mem)) begin
			cause            = int_trap ? CAUSE_TRAP : CAUSE_TAKEN;
			ctl.bubble_ifid  = 1'b1;
			ctl.bubble_idex  = 1'b1;
			ctl.bubble_exmem = 1'b1;
			ctl.write_ifid   = 1'b0;
			ctl.write_idex   = 1'b0;
			ctl.write_exmem  = 1'b0;
			ctl.write_pc     = 1'b1;
		end
	end

	a_no_bubble_in_mem_wait: assert property (
		@(posedge ctl.clk) disable iff (ctl.rst)
		(cause == CAUSE_MEM) |->
			!(ctl.bubble_ifid || ctl.bubble_idex || ctl.bubble_exmem)
	);

	a_ifid_write_xor_bubble: assert property (
		@(posedge ctl.clk) disable iff (ctl.rst)
		!(ctl.write_ifid && ctl.bubble_ifid)
	);

endmodule

`default_nettype wire

// File: logic/mem_port.sv
`timescale 1ns/1ns
`default_nettype none

// four-phase req/ack master for loads and stores sitting in EX/MEM
module mem_port
	import pipe_types_pkg::*;
	import ctrl_types_pkg::*;
(
	input  wire logic   clk,
	input  wire logic   rst,
	input  wire instr_t exmem,
	output logic        mem_req,
	input  wire logic   mem_ack,
	output mem_op_t     mem_op,
	output logic [TAG_W-1:0] mem_tag,
	output logic        mem_ready
);

	typedef enum logic [1:0] {
		IDLE    = 2'd0,
		REQ     = 2'd1,
		RELEASE = 2'd2, // req dropped, waiting for ack to fall
		DONE    = 2'd3
	} state_t;

	state_t state, next_state;
	logic   is_mem;

	assign is_mem = exmem.valid && ((exmem.op == OP_LOAD) || (exmem.op == OP_STORE));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE:    if (is_mem && !mem_ack) next_state = REQ; // previous ack must be gone
			REQ:     if (mem_ack) next_state = RELEASE;
			RELEASE: if (!mem_ack) next_state = DONE;
			DONE:    next_state = IDLE; // pipeline moves on in this cycle
			default: next_state = IDLE;
		endcase
	end

	assign mem_req   = (state == REQ);
	assign mem_op    = (exmem.op == OP_STORE) ? MEM_WR : MEM_RD;
	assign mem_tag   = exmem.tag; // EX/MEM is frozen while the exchange runs
	assign mem_ready = !is_mem || (state == DONE);

	a_req_after_ack_low: assert property (
		@(posedge clk) disable iff (rst)
		$rose(mem_req) |-> !mem_ack
	);

endmodule

`default_nettype wire

// File: logic/pipe_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module pipe_ctrl_top
	import pipe_types_pkg::*;
	import ctrl_types_pkg::*;
(
	input  wire logic             clk,
	input  wire logic             rst,

	// fetch side
	input  wire logic             fetch_valid,
	input  wire logic [TAG_W-1:0] fetch_tag,
	input  wire op_t              fetch_op,
	input  wire logic [REG_W-1:0] fetch_rd,
	input  wire logic [REG_W-1:0] fetch_rs,
	input  wire logic [REG_W-1:0] fetch_rt,
	input  wire logic             fetch_taken,
	output logic                  fetch_take,

	input  wire logic             int_trap,

	// memory side
	output logic                  mem_req,
	input  wire logic             mem_ack,
	output mem_op_t               mem_op,
	output logic [TAG_W-1:0]      mem_tag,

	output logic                  retire_valid,
	output logic [TAG_W-1:0]      retire_tag,
	output logic                  trap_waiting
);

	instr_t fetch_instr;
	instr_t ifid_q, idex_q, exmem_q, memwb_q;
	logic   mem_ready;

	stage_ctrl_if ctl (
		.clk (clk),
		.rst (rst)
	);

	assign fetch_instr = '{
		valid: fetch_valid,
		tag:   fetch_tag,
		op:    fetch_op,
		rd:    fetch_rd,
		rs:    fetch_rs,
		rt:    fetch_rt,
		taken: fetch_taken
	};

	assign fetch_take   = ctl.write_pc;
	assign trap_waiting = ctl.trap_waiting;
	assign retire_valid = memwb_q.valid && ctl.write_memwb; // one pulse, also under a freeze
	assign retire_tag   = memwb_q.tag;

	stage_reg #(.payload_t(instr_t)) u_ifid (
		.clk    (clk),
		.rst    (rst),
		.write  (ctl.write_ifid),
		.bubble (ctl.bubble_ifid),
		.d      (fetch_instr),
		.q      (ifid_q)
	);

	stage_reg #(.payload_t(instr_t)) u_idex (
		.clk    (clk),
		.rst    (rst),
		.write  (ctl.write_idex),
		.bubble (ctl.bubble_idex),
		.d      (ifid_q),
		.q      (idex_q)
	);

	stage_reg #(.payload_t(instr_t)) u_exmem (
		.clk    (clk),
		.rst    (rst),
		.write  (ctl.write_exmem),
		.bubble (ctl.bubble_exmem),
		.d      (idex_q),
		.q      (exmem_q)
	);

	// last stage is never flushed
	stage_reg #(.payload_t(instr_t)) u_memwb (
		.clk    (clk),
		.rst    (rst),
		.write  (ctl.write_memwb),
		.bubble (1'b0),
		.d      (exmem_q),
		.q      (memwb_q)
	);

	hazard_ctrl u_hazard (
		.ctl       (ctl),
		.ifid      (ifid_q),
		.idex      (idex_q),
		.exmem     (exmem_q),
		.mem_ready (mem_ready),
		.int_trap  (int_trap)
	);

	mem_port u_mem_port (
		.clk       (clk),
		.rst       (rst),
		.exmem     (exmem_q),
		.mem_req   (mem_req),
		.mem_ack   (mem_ack),
		.mem_op    (mem_op),
		.mem_tag   (mem_tag),
		.mem_ready (mem_ready)
	);

endmodule

`default_nettype wire

// File: logic/pipe_types_pkg.sv
`default_nettype none

package pipe_types_pkg;

	localparam int REG_W = 5; // register number width
	localparam int TAG_W = 8; // instruction tag width

	// operation class carried down the pipe
	typedef enum logic [2:0] {
		OP_ALU     = 3'd0,
		OP_LOAD    = 3'd1,
		OP_STORE   = 3'd2,
		OP_BRANCH  = 3'd3,
		OP_JUMP    = 3'd4,
		OP_SYSCALL = 3'd5
	} op_t;

	// one instruction slot, valid clear means bubble
	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
		op_t              op;
		logic [REG_W-1:0] rd;  // destination
		logic [REG_W-1:0] rs;
		logic [REG_W-1:0] rt;
		logic             taken; // resolved direction, branches only
	} instr_t;

endpackage

`default_nettype wire

// File: logic/stage_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

// write and bubble enables from the hazard unit to the stage registers
interface stage_ctrl_if (
	input wire logic clk, // for checks on the control side
	input wire logic rst
);
	logic write_pc;
	logic write_ifid;
	logic write_idex;
	logic write_exmem;
	logic write_memwb;
	logic bubble_ifid;
	logic bubble_idex;
	logic bubble_exmem;
	logic trap_waiting;

	modport ctrl (
		input  clk, rst,
		output write_pc, write_ifid, write_idex, write_exmem, write_memwb,
		output bubble_ifid, bubble_idex, bubble_exmem, trap_waiting
	);

	modport pipe (
		input clk, rst,
		input write_pc, write_ifid, write_idex, write_exmem, write_memwb,
		input bubble_ifid, bubble_idex, bubble_exmem, trap_waiting
	);
endinterface

`default_nettype wire

// File: logic/stage_reg.sv
`timescale 1ns/1ns
`default_nettype none

// one pipeline slot; an all-zero payload is a bubble
module stage_reg #(
	parameter type payload_t = logic [7:0]
) (
	input  wire logic     clk,
	input  wire logic     rst,
	input  wire logic     write,
	input  wire logic     bubble,
	input  wire payload_t d,
	output payload_t      q
);

	always_ff @(posedge clk) begin
		if (rst || bubble) begin
			q <= payload_t'(0); // bubble wins over write
		end else if (write) begin
			q <= d;
		end
	end

	// slot comes out of reset empty
	a_empty_after_rst: assert property (
		@(posedge clk) rst |=> (q == payload_t'(0))
	);

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the pipeline control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_pipe_ctrl \
	--Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
	cat sim.log
	echo "simulation did not complete"
	exit 1
fi

cat sim.log
if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "no result line in sim.log"
	exit 1
fi
exit 0

// File: sources.f
logic/pipe_types_pkg.sv
logic/ctrl_types_pkg.sv
logic/stage_ctrl_if.sv
logic/stage_reg.sv
logic/hazard_ctrl.sv
logic/mem_port.sv
logic/pipe_ctrl_top.sv
verification/tb_pipe_ctrl.sv

// File: verification/tb_pipe_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_ctrl
	import pipe_types_pkg::*;
	import ctrl_types_pkg::*;
;
	logic clk, rst;
	logic fetch_valid, fetch_taken, fetch_take, int_trap;
	logic [TAG_W-1:0] fetch_tag, mem_tag, retire_tag;
	op_t fetch_op;
	logic [REG_W-1:0] fetch_rd, fetch_rs, fetch_rt;
	logic mem_req, mem_ack, retire_valid, trap_waiting;
	mem_op_t mem_op;

	int err_count = 0;
	int assert_fails = 0;
	string test_name = "reset";
	logic [TAG_W-1:0] next_tag = 8'h01;
	op_t op_of [256];
	logic [TAG_W-1:0] exp_tags [$]; // expected retirement order
	bit exp_opt [$];                // entry may or may not retire (older than a trap)
	logic [TAG_W-1:0] done_tags [$]; // finished memory exchanges
	bit after_jump = 0;
	bit in_shadow = 0;
	logic [TAG_W-1:0] shadow_tag;

	pipe_ctrl_top uut (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (!rst) begin
			if (retire_valid) begin
				if (exp_tags.size() > 0 && exp_opt[0] && exp_tags[0] != retire_tag) begin
					void'(exp_tags.pop_front()); // the optional one was flushed
					void'(exp_opt.pop_front());
				end
				if (exp_tags.size() == 0) begin
					$display("tag %0h retired while nothing was expected", retire_tag);
					err_count++;
				end else begin
					assert (retire_tag == exp_tags[0]) else begin
						$display("ERR %s: expected %0h, actual %0h", test_name,
							exp_tags[0], retire_tag);
						err_count++;
					end
					void'(exp_tags.pop_front());
					void'(exp_opt.pop_front());
				end
				if (in_shadow && retire_tag == shadow_tag)
					in_shadow = 0;
				if (op_of[retire_tag] == OP_LOAD || op_of[retire_tag] == OP_STORE) begin
					if (done_tags.size() == 0) begin
						$display("memory op %0h retired without an exchange", retire_tag);
						err_count++;
					end else begin
						assert (done_tags[0] == retire_tag) else begin
							$display("ERR %s: expected %0h, actual %0h", test_name,
								retire_tag, done_tags[0]);
							err_count++;
						end
						void'(done_tags.pop_front());
					end
				end
			end
			if (int_trap) begin
				// only the oldest in flight can still make it out
				while (exp_tags.size() > 1) begin
					void'(exp_tags.pop_back());
					void'(exp_opt.pop_back());
				end
				if (exp_opt.size() == 1)
					exp_opt[0] = 1;
				after_jump = 0;
			end else if (fetch_valid && fetch_take) begin
				if (after_jump)
					after_jump = 0; // squashed behind the jump
				else if (!in_shadow) begin
					exp_tags.push_back(fetch_tag);
					exp_opt.push_back(0);
					after_jump = (fetch_op == OP_JUMP);
					if (fetch_op == OP_BRANCH && fetch_taken) begin
						in_shadow = 1;
						shadow_tag = fetch_tag;
					end
				end
			end
		end
	end

	// four-phase memory responder with random delays
	always begin
		logic [TAG_W-1:0] tag;
		mem_op_t exp_dir;
		int n;
		@(posedge clk);
		if (!rst && mem_req && !mem_ack) begin
			tag = mem_tag;
			exp_dir = (op_of[tag] == OP_LOAD) ? MEM_RD : MEM_WR; // loads read, stores write
			assert (mem_op == exp_dir) else begin
				$display("ERR %s: expected %0d, actual %0d", test_name, exp_dir, mem_op);
				err_count++;
			end
			repeat ($urandom_range(0, 3)) @(posedge clk);
			#2 mem_ack = 1;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (mem_req && n < 50);
			if (mem_req) begin
				$display("mem_req was not released after ack");
				err_count++;
			end
			repeat ($urandom_range(0, 3)) @(posedge clk);
			#2 mem_ack = 0;
			done_tags.push_back(tag);
		end
	end

	a_mem_freeze: assert property (@(posedge clk) disable iff (rst)
		(mem_req || mem_ack) |-> !retire_valid)
		else begin
			assert_fails++;
			$display("retire during memory wait in %s", test_name);
		end
	a_tag_stable: assert property (@(posedge clk) disable iff (rst)
		(mem_req && $past(mem_req)) |-> $stable(mem_tag))
		else begin
			assert_fails++;
			$display("mem_tag changed during a request");
		end
	a_reset_quiet: assert property (@(posedge clk)
		$fell(rst) |-> (!retire_valid && !mem_req && !trap_waiting))
		else begin
			assert_fails++;
			$display("outputs active right after reset");
		end

	task automatic issue(input op_t op, input int rd, input int rs, input int rt,
		input logic taken, output int waited);
		int n;
		fetch_valid = 1;
		fetch_tag   = next_tag;
		fetch_op    = op;
		fetch_rd    = REG_W'(rd);
		fetch_rs    = REG_W'(rs);
		fetch_rt    = REG_W'(rt);
		fetch_taken = taken;
		op_of[next_tag] = op;
		n = 0;
		@(posedge clk);
		while (!fetch_take && n < 100) begin
			n++;
			@(posedge clk);
		end
		waited = n;
		if (n >= 100) begin
			$display("fetch of tag %0h was never accepted", next_tag);
			err_count++;
		end
		next_tag++;
		#2;
	endtask

	function automatic bit pending_required();
		foreach (exp_opt[i])
			if (!exp_opt[i])
				return 1;
		return in_shadow;
	endfunction

	task automatic drain();
		int n;
		fetch_valid = 0;
		n = 0;
		while (pending_required() && n < 300) begin
			@(posedge clk);
			n++;
		end
		if (n >= 300) begin
			$display("pipeline did not drain in %s", test_name);
			err_count++;
		end
		repeat (4) @(posedge clk);
		#2;
	endtask

	task automatic random_stream(input int count, input bit alu_only);
		int w, r;
		op_t op;
		for (int i = 0; i < count; i++) begin
			r = alu_only ? 0 : $urandom_range(0, 19);
			op = (r >= 10 && r <= 11) ? OP_LOAD : (r <= 13 && r >= 12) ? OP_STORE :
				(r == 14 || r == 15) ? OP_BRANCH : (r == 16) ? OP_JUMP :
				(r == 17) ? OP_SYSCALL : OP_ALU;
			if (i >= count - 3)
				op = OP_ALU; // close with plain ops
			issue(op, $urandom_range(0, 7), $urandom_range(0, 7), $urandom_range(0, 7),
				logic'($urandom_range(0, 1)), w);
		end
	endtask

	initial begin
		int w, n;
		void'($urandom(62));
		clk = 0;
		rst = 1;
		fetch_valid = 0;
		fetch_tag = '0;
		fetch_op = OP_ALU;
		fetch_rd = '0;
		fetch_rs = '0;
		fetch_rt = '0;
		fetch_taken = 0;
		int_trap = 0;
		mem_ack = 0;
		repeat (10) @(posedge clk);
		#2 rst = 0;

		test_name = "alu_stream";
		random_stream(20, 1);
		drain();

		test_name = "load_use";
		issue(OP_LOAD, 5, 1, 2, 0, w);
		issue(OP_ALU, 6, 5, 3, 0, w);
		issue(OP_ALU, 7, 1, 1, 0, w);
		assert (w >= 1) else begin
			$display("ERR %s: expected %0d, actual %0d", test_name, 1, w);
			err_count++;
		end
		issue(OP_ALU, 2, 3, 4, 0, w);
		drain();

		test_name = "mem_ops";
		issue(OP_STORE, 0, 1, 2, 0, w);
		issue(OP_LOAD, 3, 1, 2, 0, w); // load behind store
		issue(OP_ALU, 4, 0, 0, 0, w);
		issue(OP_LOAD, 6, 4, 4, 0, w);
		issue(OP_STORE, 0, 6, 6, 0, w);
		issue(OP_ALU, 1, 2, 2, 0, w);
		drain();

		test_name = "jump_branch";
		issue(OP_ALU, 1, 0, 0, 0, w);
		issue(OP_JUMP, 0, 0, 0, 0, w);
		issue(OP_ALU, 2, 0, 0, 0, w);
		issue(OP_ALU, 3, 0, 0, 0, w);
		issue(OP_BRANCH, 0, 1, 2, 1, w);
		for (int i = 0; i < 4; i++)
			issue(OP_ALU, 4, 0, 0, 0, w);
		issue(OP_BRANCH, 0, 1, 2, 0, w);
		for (int i = 0; i < 3; i++)
			issue(OP_ALU, 5, 0, 0, 0, w);
		drain();

		test_name = "random";
		random_stream(60, 0);
		drain();

		test_name = "trap";
		fork
			random_stream(12, 1);
			begin
				repeat (6) @(posedge clk);
				#2 int_trap = 1;
				@(posedge clk);
				#2 int_trap = 0;
			end
		join
		drain();

		test_name = "trap_waiting";
		issue(OP_BRANCH, 0, 1, 1, 0, w);
		issue(OP_SYSCALL, 0, 0, 0, 0, w);
		fetch_valid = 0;
		n = 0;
		@(posedge clk);
		while (!trap_waiting && n < 20) begin
			n++;
			@(posedge clk);
		end
		if (!trap_waiting) begin
			$display("trap_waiting never rose for a held syscall");
			err_count++;
		end
		#2;
		drain();

		if (done_tags.size() != 0) begin
			$display("%0d memory exchanges without a retiring load or store", done_tags.size());
			err_count++;
		end
		$display("errors: %0d checks, %0d assertions", err_count, assert_fails);
		if (err_count == 0 && assert_fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
